// File: mips_pkg.sv
package mips_pkg;

    ////////////////////
    // Widths
    ////////////////////

    typedef logic [31:0] word_t;        // Data and address word
    typedef logic [4:0]  reg_addr_t;    // Register index
    typedef logic [5:0]  op_t;          // Opcode or funct field
    typedef logic [3:0]  alu_ctrl_t;    // ALU and hi/lo operation
    typedef logic [1:0]  sel_wa_t;      // Write address select
    typedef logic [1:0]  sel_result_t;  // Writeback source
    typedef logic [1:0]  sel_pc_t;      // Next pc source

    ////////////////////
    // Opcodes
    ////////////////////

    localparam op_t OPCODE_R    = 6'h00;
    localparam op_t OPCODE_J    = 6'h02;
    localparam op_t OPCODE_JAL  = 6'h03;
    localparam op_t OPCODE_BEQ  = 6'h04;
    localparam op_t OPCODE_ADDI = 6'h08;
    localparam op_t OPCODE_LW   = 6'h23;
    localparam op_t OPCODE_SW   = 6'h2b;

    // R-type funct codes
    localparam op_t FUNCT_JR    = 6'h08;
    localparam op_t FUNCT_MFHI  = 6'h10;
    localparam op_t FUNCT_MFLO  = 6'h12;
    localparam op_t FUNCT_MULTU = 6'h19;
    localparam op_t FUNCT_DIVU  = 6'h1b;
    localparam op_t FUNCT_ADD   = 6'h20;
    localparam op_t FUNCT_SUB   = 6'h22;
    localparam op_t FUNCT_AND   = 6'h24;
    localparam op_t FUNCT_OR    = 6'h25;
    localparam op_t FUNCT_SLT   = 6'h2a;

    ////////////////////
    // ALU codes
    ////////////////////

    localparam alu_ctrl_t ADD_AC   = 4'd0;
    localparam alu_ctrl_t SUB_AC   = 4'd1;
    localparam alu_ctrl_t AND_AC   = 4'd2;
    localparam alu_ctrl_t OR_AC    = 4'd3;
    localparam alu_ctrl_t SLT_AC   = 4'd4;
    localparam alu_ctrl_t MULTU_AC = 4'd5;   // Loads hi/lo with product
    localparam alu_ctrl_t DIVU_AC  = 4'd6;   // Loads hi/lo with rem/quot
    localparam alu_ctrl_t MFHI_AC  = 4'd7;
    localparam alu_ctrl_t MFLO_AC  = 4'd8;
    localparam alu_ctrl_t JR_AC    = 4'd9;   // ALU idle, pc takes rs

    // Mux selects
    localparam sel_wa_t     SEL_WA_RT     = 2'd0;
    localparam sel_wa_t     SEL_WA_RD     = 2'd1;
    localparam sel_wa_t     SEL_WA_RA     = 2'd2;   // Link register 31
    localparam sel_result_t SEL_RES_ALU   = 2'd0;
    localparam sel_result_t SEL_RES_MEM   = 2'd1;
    localparam sel_result_t SEL_RES_PC4   = 2'd2;
    localparam sel_result_t SEL_RES_HILO  = 2'd3;
    localparam sel_pc_t     SEL_PC_SEQ    = 2'd0;   // pc+4 or branch
    localparam sel_pc_t     SEL_PC_JUMP   = 2'd1;
    localparam sel_pc_t     SEL_PC_REG    = 2'd2;

endpackage

// File: control_unit.sv
`timescale 1ns/1ns

module control_unit
    import mips_pkg::*;
(
    input  op_t         opcode,
    input  op_t         funct,
    output logic        rf_we,
    output sel_wa_t     sel_wa,
    output logic        sel_alu_b,
    output logic        dmem_we,
    output sel_result_t sel_result,
    output sel_pc_t     sel_pc,
    output logic        branch,
    output alu_ctrl_t   alu_ctrl
);

    // Coarse ALU class from the main decoder
    localparam logic [1:0] ALU_OP_ADD   = 2'b00;
    localparam logic [1:0] ALU_OP_SUB   = 2'b01;
    localparam logic [1:0] ALU_OP_FUNCT = 2'b10;

    // Field order of the control word
    // rf_we, sel_wa, sel_alu_b, dmem_we, sel_result, sel_pc, branch, alu_op
    localparam logic [11:0] CTRL_LW    = {1'b1, SEL_WA_RT, 1'b1, 1'b0, SEL_RES_MEM,
                                          SEL_PC_SEQ, 1'b0, ALU_OP_ADD};
    localparam logic [11:0] CTRL_SW    = {1'b0, SEL_WA_RT, 1'b1, 1'b1, SEL_RES_ALU,
                                          SEL_PC_SEQ, 1'b0, ALU_OP_ADD};
    localparam logic [11:0] CTRL_BEQ   = {1'b0, SEL_WA_RT, 1'b0, 1'b0, SEL_RES_ALU,
                                          SEL_PC_SEQ, 1'b1, ALU_OP_SUB};
    localparam logic [11:0] CTRL_ADDI  = {1'b1, SEL_WA_RT, 1'b1, 1'b0, SEL_RES_ALU,
                                          SEL_PC_SEQ, 1'b0, ALU_OP_ADD};
    localparam logic [11:0] CTRL_J     = {1'b0, SEL_WA_RT, 1'b0, 1'b0, SEL_RES_ALU,
                                          SEL_PC_JUMP, 1'b0, ALU_OP_ADD};
    localparam logic [11:0] CTRL_JAL   = {1'b1, SEL_WA_RA, 1'b0, 1'b0, SEL_RES_PC4,
                                          SEL_PC_JUMP, 1'b0, ALU_OP_ADD};
    localparam logic [11:0] CTRL_R     = {1'b1, SEL_WA_RD, 1'b0, 1'b0, SEL_RES_ALU,
                                          SEL_PC_SEQ, 1'b0, ALU_OP_FUNCT};
    localparam logic [11:0] CTRL_MF    = {1'b1, SEL_WA_RD, 1'b0, 1'b0, SEL_RES_HILO,
                                          SEL_PC_SEQ, 1'b0, ALU_OP_FUNCT};
    localparam logic [11:0] CTRL_JR    = {1'b0, SEL_WA_RD, 1'b0, 1'b0, SEL_RES_ALU,
                                          SEL_PC_REG, 1'b0, ALU_OP_FUNCT};
    localparam logic [11:0] CTRL_MD    = {1'b0, SEL_WA_RD, 1'b0, 1'b0, SEL_RES_ALU,
                                          SEL_PC_SEQ, 1'b0, ALU_OP_FUNCT};
    localparam logic [11:0] CTRL_NOP   = '0;   // Plain pc+4, nothing written

    logic [1:0]  alu_op;
    logic [11:0] ctrl;

    assign {rf_we, sel_wa, sel_alu_b, dmem_we, sel_result, sel_pc, branch, alu_op} = ctrl;

    ////////////////////
    // Main decoder
    ////////////////////

    always_comb begin
        case (opcode)
            OPCODE_LW:   ctrl = CTRL_LW;
            OPCODE_SW:   ctrl = CTRL_SW;
            OPCODE_BEQ:  ctrl = CTRL_BEQ;
            OPCODE_ADDI: ctrl = CTRL_ADDI;
            OPCODE_J:    ctrl = CTRL_J;
            OPCODE_JAL:  ctrl = CTRL_JAL;
            OPCODE_R: begin
                case (funct)
                    FUNCT_ADD, FUNCT_SUB, FUNCT_AND,
                    FUNCT_OR, FUNCT_SLT:       ctrl = CTRL_R;
                    FUNCT_MFHI, FUNCT_MFLO:    ctrl = CTRL_MF;
                    FUNCT_JR:                  ctrl = CTRL_JR;   // No register write
                    FUNCT_MULTU, FUNCT_DIVU:   ctrl = CTRL_MD;   // Only hi/lo change
                    default:                   ctrl = CTRL_NOP;
                endcase
            end
            default:     ctrl = CTRL_NOP;   // Unknown opcode
        endcase
    end

    // ALU decoder
    always_comb begin
        case (alu_op)
            ALU_OP_ADD: alu_ctrl = ADD_AC;   // Address calc, addi
            ALU_OP_SUB: alu_ctrl = SUB_AC;   // beq compare
            default: begin
                case (funct)
                    FUNCT_ADD:   alu_ctrl = ADD_AC;
                    FUNCT_SUB:   alu_ctrl = SUB_AC;
                    FUNCT_AND:   alu_ctrl = AND_AC;
                    FUNCT_OR:    alu_ctrl = OR_AC;
                    FUNCT_SLT:   alu_ctrl = SLT_AC;
                    FUNCT_MULTU: alu_ctrl = MULTU_AC;
                    FUNCT_DIVU:  alu_ctrl = DIVU_AC;
                    FUNCT_MFHI:  alu_ctrl = MFHI_AC;
                    FUNCT_MFLO:  alu_ctrl = MFLO_AC;
                    FUNCT_JR:    alu_ctrl = JR_AC;
                    default:     alu_ctrl = ADD_AC;
                endcase
            end
        endcase
    end

endmodule

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  reg_addr_t wa,
    input  logic      we,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);

    word_t regs [32];   // Architectural registers

    // Register 0 never written, so it stays at reset value
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous read ports
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu
    import mips_pkg::*;
(
    input  word_t     a,
    input  word_t     b,
    input  alu_ctrl_t alu_ctrl,
    output word_t     result,
    output logic      zero
);

    word_t sum;
    word_t diff;
    logic  lt;

    assign sum  = a + b;                       // Wraps, no overflow trap
    assign diff = a - b;
    assign lt   = $signed(a) < $signed(b);     // Signed compare for slt

    // Equal operands for beq
    assign zero = (diff == '0);

    always_comb begin
        case (alu_ctrl)
            ADD_AC:  result = sum;
            SUB_AC:  result = diff;
            AND_AC:  result = a & b;
            OR_AC:   result = a | b;
            SLT_AC:  result = {31'b0, lt};
            default: result = sum;   // hi/lo and jr codes leave ALU unused
        endcase
    end

endmodule

// File: muldiv_unit.sv
`timescale 1ns/1ns

module muldiv_unit
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  word_t     a,
    input  word_t     b,
    input  alu_ctrl_t alu_ctrl,
    output word_t     hilo_out
);

    word_t       hi;
    word_t       lo;
    logic [63:0] product;
    word_t       quot;
    word_t       rem;

    assign product = a * b;   // Unsigned 64-bit product

    // Divide by zero gives all-ones quotient, dividend as remainder
    assign quot = (b == '0) ? '1 : a / b;
    assign rem  = (b == '0) ? a  : a % b;

    ////////////////////
    // hi/lo registers
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hi <= '0;
            lo <= '0;
        end else if (alu_ctrl == MULTU_AC) begin
            hi <= product[63:32];
            lo <= product[31:0];
        end else if (alu_ctrl == DIVU_AC) begin
            hi <= rem;
            lo <= quot;
        end
    end

    assign hilo_out = (alu_ctrl == MFHI_AC) ? hi : lo;   // mflo otherwise

endmodule

// File: pc_unit.sv
`timescale 1ns/1ns

module pc_unit
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic        clk,
    input  logic        arst_n,
    input  sel_pc_t     sel_pc,
    input  logic        branch,
    input  logic        zero,
    input  word_t       imm_ext,
    input  logic [25:0] jump_index,
    input  word_t       rs_value,
    output word_t       pc,
    output word_t       pc_plus4
);

    word_t branch_target;
    word_t jump_target;
    word_t pc_next;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};   // Word offset
    assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};    // Same 256MB region

    // Next pc
    always_comb begin
        case (sel_pc)
            SEL_PC_SEQ:  pc_next = (branch && zero) ? branch_target : pc_plus4;
            SEL_PC_JUMP: pc_next = jump_target;
            SEL_PC_REG:  pc_next = rs_value;   // jr
            default:     pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: mips_core.sv
`timescale 1ns/1ns

module mips_core
    import mips_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  arst_n,
    input  word_t instr,        // Fetched combinationally at imem_addr
    input  word_t dmem_rdata,
    output word_t imem_addr,
    output logic  dmem_we,
    output word_t dmem_addr,
    output word_t dmem_wdata
);

    ////////////////////
    // Instruction fields
    ////////////////////

    op_t         opcode;
    op_t         funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;
    logic [25:0] jump_index;
    word_t       imm_ext;

    assign opcode     = instr[31:26];
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd         = instr[15:11];
    assign funct      = instr[5:0];
    assign imm        = instr[15:0];
    assign jump_index = instr[25:0];
    assign imm_ext    = {{16{imm[15]}}, imm};   // Sign extend

    // Control levels
    logic        rf_we;
    sel_wa_t     sel_wa;
    logic        sel_alu_b;
    sel_result_t sel_result;
    sel_pc_t     sel_pc;
    logic        branch;
    alu_ctrl_t   alu_ctrl;

    // Datapath
    word_t       rd1;
    word_t       rd2;
    word_t       alu_b;
    word_t       alu_result;
    logic        zero;
    word_t       hilo_out;
    word_t       pc;
    word_t       pc_plus4;
    reg_addr_t   wa;
    word_t       result;

    control_unit u_control (
        .opcode     (opcode),
        .funct      (funct),
        .rf_we      (rf_we),
        .sel_wa     (sel_wa),
        .sel_alu_b  (sel_alu_b),
        .dmem_we    (dmem_we),
        .sel_result (sel_result),
        .sel_pc     (sel_pc),
        .branch     (branch),
        .alu_ctrl   (alu_ctrl)
    );

    // Write address, rt for I-type, rd for R-type, 31 for jal
    always_comb begin
        case (sel_wa)
            SEL_WA_RD: wa = rd;
            SEL_WA_RA: wa = 5'd31;
            default:   wa = rt;
        endcase
    end

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (rs),
        .ra2    (rt),
        .wa     (wa),
        .we     (rf_we),
        .wd     (result),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    assign alu_b = sel_alu_b ? imm_ext : rd2;   // Immediate for lw, sw, addi

    alu u_alu (
        .a        (rd1),
        .b        (alu_b),
        .alu_ctrl (alu_ctrl),
        .result   (alu_result),
        .zero     (zero)
    );

    muldiv_unit u_muldiv (
        .clk      (clk),
        .arst_n   (arst_n),
        .a        (rd1),
        .b        (rd2),
        .alu_ctrl (alu_ctrl),
        .hilo_out (hilo_out)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) u_pc (
        .clk        (clk),
        .arst_n     (arst_n),
        .sel_pc     (sel_pc),
        .branch     (branch),
        .zero       (zero),
        .imm_ext    (imm_ext),
        .jump_index (jump_index),
        .rs_value   (rd1),
        .pc         (pc),
        .pc_plus4   (pc_plus4)
    );

    // Writeback source
    always_comb begin
        case (sel_result)
            SEL_RES_MEM:  result = dmem_rdata;
            SEL_RES_PC4:  result = pc_plus4;   // jal link
            SEL_RES_HILO: result = hilo_out;
            default:      result = alu_result;
        endcase
    end

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rd2;

endmodule

// File: mips_core_chk.sv
`timescale 1ns/1ns

module mips_core_chk
    import mips_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input op_t   opcode,
    input op_t   funct,
    input word_t pc,
    input logic  dmem_we,
    input logic  rf_we,
    input word_t link_reg   // Register 31
);

    int unsigned fail_count = 0;   // Fired assertions so far

    logic no_write_op;

    // Instructions that leave the register file alone
    assign no_write_op = (opcode == OPCODE_SW) || (opcode == OPCODE_BEQ) ||
                         (opcode == OPCODE_J) ||
                         ((opcode == OPCODE_R) &&
                          ((funct == FUNCT_JR) || (funct == FUNCT_MULTU) ||
                           (funct == FUNCT_DIVU)));

    ////////////////////
    // Properties
    ////////////////////

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("pc %h is not word aligned", pc);
        end

    store_only_on_sw: assert property (@(posedge clk) disable iff (!arst_n)
        dmem_we |-> (opcode == OPCODE_SW))
        else begin
            fail_count++;
            $error("dmem_we high for opcode %h", opcode);
        end

    no_reg_write: assert property (@(posedge clk) disable iff (!arst_n)
        no_write_op |-> !rf_we)
        else begin
            fail_count++;
            $error("rf_we high for opcode %h funct %h", opcode, funct);
        end

    // Link is the jal address plus one word
    jal_links: assert property (@(posedge clk) disable iff (!arst_n)
        (opcode == OPCODE_JAL) |=> (link_reg == $past(pc) + 32'd4))
        else begin
            fail_count++;
            $error("register 31 holds %h after jal", link_reg);
        end

endmodule

bind mips_core mips_core_chk u_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .opcode   (opcode),
    .funct    (funct),
    .pc       (pc),
    .dmem_we  (dmem_we),
    .rf_we    (rf_we),
    .link_reg (u_reg_file.regs[31])
);

// File: tb_mips_core.sv
`timescale 1ns/1ns

module tb_mips_core
    import mips_pkg::*;
();

    localparam word_t RESET_PC   = 32'h0000_0080;   // First fetch, mid array
    localparam int    CLK_PERIOD = 4;
    localparam int    NUM_INSTR  = 2000;
    localparam int    TIMEOUT_NS = (NUM_INSTR + 3 + 50) * CLK_PERIOD;   // Reset plus margin

    logic  clk = 1'b0;
    logic  arst_n;
    word_t instr;
    word_t dmem_rdata;
    word_t imem_addr;
    logic  dmem_we;
    word_t dmem_addr;
    word_t dmem_wdata;

    word_t prog [64];   // Instruction memory
    word_t dmem [64];   // Data memory as the DUT sees it

    // Reference ISA state
    word_t       mreg [32];
    word_t       mmem [64];
    word_t       mhi;
    word_t       mlo;
    word_t       mpc;
    int          retired = 0;
    logic [31:0] rng = 32'hf2c8_c69b;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_core #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .instr      (instr),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata)
    );

    // Both memories answer combinationally
    assign instr      = prog[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic fail_value(input string msg);
        stop_run($sformatf("[FAIL] t=%0t ns %s", $time, msg));
    endtask

    // Random legal instruction for one program slot
    task automatic make_instr(input int slot, output word_t ins);
        logic [31:0] r;
        reg_addr_t   dst;
        reg_addr_t   src_a;
        reg_addr_t   src_b;
        logic [5:0]  tgt;
        logic [15:0] off;
        rng   = xorshift32(rng);
        r     = rng;
        dst   = {2'b00, r[6:4]};                  // r0 now and then
        src_a = 5'(1 + r[9:7] % 7);
        src_b = r[31] ? src_a : 5'(1 + r[12:10] % 7);   // Same register forces beq taken
        tgt   = 6'(slot + 2 + r[18:16]);          // Forward, wraps at 64
        off   = 16'(1 + r[18:16]);                // 1 to 8 words ahead
        case (r[3:0])
            4'd0, 4'd1: ins = {OPCODE_ADDI, src_a, dst, {{4{r[27]}}, r[27:16]}};
            4'd2:    ins = {OPCODE_R, src_a, src_b, dst, 5'd0, FUNCT_ADD};
            4'd3:    ins = {OPCODE_R, src_a, src_b, dst, 5'd0, FUNCT_SUB};
            4'd4:    ins = {OPCODE_R, src_a, src_b, dst, 5'd0, FUNCT_AND};
            4'd5:    ins = {OPCODE_R, src_a, src_b, dst, 5'd0, FUNCT_OR};
            4'd6:    ins = {OPCODE_R, src_a, src_b, dst, 5'd0, FUNCT_SLT};
            4'd7:    ins = {OPCODE_SW, 5'd0, src_a, 8'd0, r[21:16], 2'b00};
            4'd8:    ins = {OPCODE_LW, 5'd0, dst, 8'd0, r[21:16], 2'b00};
            4'd9:    ins = {OPCODE_BEQ, src_a, src_b, off};
            4'd10:   ins = {OPCODE_J, 20'd0, tgt};
            4'd11:   ins = {OPCODE_JAL, 20'd0, tgt};
            4'd12:   ins = {OPCODE_R, 5'd31, 15'd0, FUNCT_JR};   // Return through link
            4'd13:   ins = {OPCODE_R, src_a, src_b, 10'd0, FUNCT_MULTU};
            4'd14:   ins = {OPCODE_R, src_a, src_b, 10'd0, FUNCT_DIVU};
            default: ins = {OPCODE_R, 10'd0, dst, 5'd0, r[31] ? FUNCT_MFHI : FUNCT_MFLO};
        endcase
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    task automatic reset_model();
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end
        mhi = '0;
        mlo = '0;
        mpc = RESET_PC;
    endtask

    task automatic write_reg(input reg_addr_t idx, input word_t val);
        if (idx != 5'd0) begin
            mreg[idx] = val;   // r0 stays zero
        end
    endtask

    task automatic step_model();
        word_t       ins;
        word_t       a;
        word_t       b;
        word_t       addr;
        word_t       npc;
        logic [63:0] prod;
        ins  = prog[mpc[7:2]];
        a    = mreg[ins[25:21]];
        b    = mreg[ins[20:16]];
        addr = a + sext(ins[15:0]);    // Also the addi sum
        npc  = mpc + 32'd4;
        case (ins[31:26])
            OPCODE_LW:   write_reg(ins[20:16], mmem[addr[7:2]]);
            OPCODE_SW:   mmem[addr[7:2]] = b;
            OPCODE_ADDI: write_reg(ins[20:16], addr);
            OPCODE_BEQ: begin
                if (a == b) begin
                    npc = npc + (sext(ins[15:0]) << 2);
                end
            end
            OPCODE_J:    npc = {npc[31:28], ins[25:0], 2'b00};
            OPCODE_JAL: begin
                write_reg(5'd31, npc);
                npc = {npc[31:28], ins[25:0], 2'b00};
            end
            OPCODE_R: begin
                case (ins[5:0])
                    FUNCT_ADD:  write_reg(ins[15:11], a + b);
                    FUNCT_SUB:  write_reg(ins[15:11], a - b);
                    FUNCT_AND:  write_reg(ins[15:11], a & b);
                    FUNCT_OR:   write_reg(ins[15:11], a | b);
                    FUNCT_SLT:  write_reg(ins[15:11], {31'b0, $signed(a) < $signed(b)});
                    FUNCT_JR:   npc = a;
                    FUNCT_MFHI: write_reg(ins[15:11], mhi);
                    FUNCT_MFLO: write_reg(ins[15:11], mlo);
                    FUNCT_MULTU: begin
                        prod = {32'b0, a} * {32'b0, b};
                        mhi  = prod[63:32];
                        mlo  = prod[31:0];
                    end
                    FUNCT_DIVU: begin
                        mlo = (b == '0) ? '1 : a / b;   // Zero divisor keeps dividend in hi
                        mhi = (b == '0) ? a : a % b;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        mpc = npc;
        retired++;
    endtask

    // Compare DUT ports with the model while they are stable
    task automatic check_outputs();
        word_t ins;
        word_t addr;
        ins  = prog[mpc[7:2]];
        addr = mreg[ins[25:21]] + sext(ins[15:0]);
        assert (imem_addr === mpc)
            else fail_value($sformatf("imem_addr %h, model pc %h", imem_addr, mpc));
        assert (dmem_we === (ins[31:26] == OPCODE_SW))
            else fail_value($sformatf("dmem_we %b for instruction %h", dmem_we, ins));
        if (ins[31:26] == OPCODE_SW) begin
            assert (dmem_addr === addr)
                else fail_value($sformatf("dmem_addr %h, expected %h", dmem_addr, addr));
            assert (dmem_wdata === mreg[ins[20:16]])
                else fail_value($sformatf("dmem_wdata %h, expected %h",
                                          dmem_wdata, mreg[ins[20:16]]));
        end
        assert (uut.u_chk.fail_count == 0)
            else stop_run("A concurrent assertion bound into the core has fired");
    endtask

    always @(posedge clk) begin : model_step
        int    slot;
        word_t fresh;
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
        if (!arst_n) begin
            reset_model();
        end else begin
            slot = int'(mpc[7:2]);
            step_model();
            make_instr(slot, fresh);
            prog[slot] <= fresh;   // Next visit runs something new
        end
    end

    always @(negedge clk) check_outputs();

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        arst_n = 1'b0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = 32'hd000_0000 | (i << 2);   // Tagged with its byte address
            mmem[i] = 32'hd000_0000 | (i << 2);
            make_instr(i, prog[i]);
        end
        prog[RESET_PC[7:2]] = {OPCODE_ADDI, 5'd0, 5'd1, 16'd5};   // No store while in reset
        reset_model();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        wait (retired >= NUM_INSTR);
        @(negedge clk);
        if (uut.u_chk.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        stop_run("Timeout: the core did not retire all instructions in time");
    end

endmodule

// File: mips_core.f
mips_pkg.sv
control_unit.sv
reg_file.sv
alu.sv
muldiv_unit.sv
pc_unit.sv
mips_core.sv
mips_core_chk.sv
tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - mips_pkg.sv
  - control_unit.sv
  - reg_file.sv
  - alu.sv
  - muldiv_unit.sv
  - pc_unit.sv
  - mips_core.sv
  - target: test
    files:
      - mips_core_chk.sv
      - tb_mips_core.sv
